// ==== keypad_subsys.f ====
+incdir+source
source/keypad_pkg.sv
source/matrix_scanner.sv
source/key_event_detector.sv
source/key_event_queue.sv
source/keypad_subsys.sv
test/keypad_model.sv
test/keypad_subsys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the keypad testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f keypad_subsys.f \
    --top-module keypad_subsys_tb \
    -o keypad_subsys_tb

./obj_dir/keypad_subsys_tb | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
    echo "simulation result: pass"
else
    echo "simulation result: fail"
    exit 1
fi

// ==== source/key_event_detector.sv ====
`timescale 1ns/10ps
`include "keypad_consts.svh"

module key_event_detector (
    input  logic clk,
    input  logic rstn,
    input  logic frame_valid,
    input  logic sample,
    output logic evt_req,
    output logic evt_release,
    input  logic evt_ack
);

    localparam keypad_pkg::frame_cnt_t STABLE_CNT = keypad_pkg::frame_cnt_t'(`STABLE_FRAMES);

    logic                   stable;    // debounced key level, 1 = pressed
    keypad_pkg::frame_cnt_t frame_cnt; // consecutive disagreeing frames
    keypad_pkg::frame_cnt_t cnt_nxt;
    logic                   flip;

    always_comb begin
        cnt_nxt = frame_cnt;
        if (frame_valid) begin
            if (sample == stable) begin
                cnt_nxt = '0;
            end else if (frame_cnt != STABLE_CNT) begin
                cnt_nxt = frame_cnt + 1'b1;  // saturates while an event waits
            end
        end
    end

    // a held change is taken as soon as the pending event has gone
    assign flip = (cnt_nxt == STABLE_CNT) && !evt_req;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            stable      <= 1'b0;
            frame_cnt   <= '0;
            evt_req     <= 1'b0;
            evt_release <= 1'b0;
        end else if (flip) begin
            stable      <= ~stable;
            frame_cnt   <= '0;
            evt_req     <= 1'b1;
            evt_release <= stable;  // was pressed, so now released
        end else begin
            frame_cnt <= cnt_nxt;
            if (evt_ack) begin
                evt_req <= 1'b0;
            end
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (!rstn)
        evt_req && !evt_ack |=> evt_req && $stable(evt_release));

endmodule

// ==== source/key_event_queue.sv ====
`timescale 1ns/10ps
`include "keypad_consts.svh"

module key_event_queue (
    input  logic                    clk,
    input  logic                    rstn,
    input  keypad_pkg::key_map_t    evt_req,
    input  keypad_pkg::key_map_t    evt_release,
    output keypad_pkg::key_map_t    evt_ack,
    output logic                    ev_valid,
    output keypad_pkg::event_code_t ev_code,
    input  logic                    credit_return
);

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`QUEUE_DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`QUEUE_DEPTH);
    localparam keypad_pkg::credit_cnt_t CREDIT_FULL =
        keypad_pkg::credit_cnt_t'(`CREDIT_INIT);

    keypad_pkg::event_code_t fifo_mem [`QUEUE_DEPTH];

    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [CNT_W-1:0]        fill_cnt;
    keypad_pkg::credit_cnt_t credit;
    keypad_pkg::key_index_t  grant_idx;
    logic                    grant_vld;
    logic                    fifo_full;
    logic                    push;
    logic                    pop;

    assign fifo_full = (fill_cnt == CNT_FULL);

    // fixed priority where key 0 wins
    always_comb begin
        grant_idx = '0;
        grant_vld = 1'b0;
        for (int i = `KEY_NUM - 1; i >= 0; i--) begin
            if (evt_req[i]) begin
                grant_idx = keypad_pkg::key_index_t'(i);
                grant_vld = 1'b1;
            end
        end
    end

    assign push = grant_vld && !fifo_full;
    assign pop = (fill_cnt != '0) && (credit != '0);  // needs an entry and a credit

    always_comb begin
        evt_ack = '0;
        if (push) begin
            evt_ack[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= {evt_release[grant_idx], grant_idx};
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fill_cnt <= '0;
        end else if (push && !pop) begin
            fill_cnt <= fill_cnt + 1'b1;
        end else if (pop && !push) begin
            fill_cnt <= fill_cnt - 1'b1;
        end
    end

    // one credit spent per event and one back per return pulse
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            credit <= CREDIT_FULL;
        end else if (pop && !credit_return) begin
            credit <= credit - 1'b1;
        end else if (credit_return && !pop) begin
            credit <= credit + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ev_valid <= 1'b0;
        end else begin
            ev_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            ev_code <= fifo_mem[rd_ptr];
        end
    end

    // only the lowest requester is acked and nobody while the fifo is full
    a_ack_onehot: assert property (@(posedge clk) disable iff (!rstn)
        evt_ack == (fifo_full ? '0 : (evt_req & (~evt_req + keypad_pkg::key_map_t'(1)))));

    a_credit_bound: assert property (@(posedge clk) disable iff (!rstn)
        credit <= CREDIT_FULL);

endmodule

// ==== source/keypad_consts.svh ====
`ifndef KEYPAD_CONSTS_SVH
`define KEYPAD_CONSTS_SVH

// matrix geometry
`define ROW_NUM 4
`define COL_NUM 4
`define KEY_NUM (`ROW_NUM * `COL_NUM)

// scan timing, sized for simulation
`define SCAN_DELAY 3      // row hold cycles minus one
`define SETTLE_TIME 8     // cycles spent settling after a scan

// debounce
`define STABLE_FRAMES 2   // agreeing frames before a change is accepted

// event path
`define QUEUE_DEPTH 4     // fifo entries
`define CREDIT_INIT 2     // credits held by the sender after reset

`endif

// ==== source/keypad_pkg.sv ====
`include "keypad_consts.svh"

package keypad_pkg;

    typedef logic [`ROW_NUM-1:0] row_vec_t;  // active low rows
    typedef logic [`COL_NUM-1:0] col_vec_t;  // pressed low columns

    // bit index is row * COL_NUM + column
    typedef logic [`KEY_NUM-1:0] key_map_t;

    typedef logic [$clog2(`KEY_NUM)-1:0] key_index_t;

    // msb set for release, low bits carry the key index
    typedef logic [$clog2(`KEY_NUM):0] event_code_t;

    typedef logic [$clog2(`CREDIT_INIT + 1)-1:0] credit_cnt_t;
    typedef logic [$clog2(`STABLE_FRAMES + 1)-1:0] frame_cnt_t;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_ROWS,
        SCAN_SETTLE
    } scan_state_t;

endpackage

// ==== source/keypad_subsys.sv ====
`timescale 1ns/10ps
`include "keypad_consts.svh"

module keypad_subsys (
    input  logic                    clk,
    input  logic                    rstn,
    output keypad_pkg::row_vec_t    row,
    input  keypad_pkg::col_vec_t    col,
    output logic                    ev_valid,
    output keypad_pkg::event_code_t ev_code,
    input  logic                    credit_return
);

    keypad_pkg::key_map_t key_map;      // scanned levels, 1 = pressed
    logic                 frame_valid;

    // one request lane per key
    keypad_pkg::key_map_t evt_req;
    keypad_pkg::key_map_t evt_release;
    keypad_pkg::key_map_t evt_ack;

    matrix_scanner u_scanner (
        .clk         (clk),
        .rstn        (rstn),
        .row         (row),
        .col         (col),
        .key_map     (key_map),
        .frame_valid (frame_valid)
    );

    for (genvar i = 0; i < `KEY_NUM; i++) begin : g_key
        key_event_detector u_detector (
            .clk         (clk),
            .rstn        (rstn),
            .frame_valid (frame_valid),
            .sample      (key_map[i]),
            .evt_req     (evt_req[i]),
            .evt_release (evt_release[i]),
            .evt_ack     (evt_ack[i])
        );
    end

    key_event_queue u_queue (
        .clk           (clk),
        .rstn          (rstn),
        .evt_req       (evt_req),
        .evt_release   (evt_release),
        .evt_ack       (evt_ack),
        .ev_valid      (ev_valid),
        .ev_code       (ev_code),
        .credit_return (credit_return)
    );

endmodule

// ==== source/matrix_scanner.sv ====
`timescale 1ns/10ps
`include "keypad_consts.svh"

module matrix_scanner (
    input  logic                 clk,
    input  logic                 rstn,
    output keypad_pkg::row_vec_t row,
    input  keypad_pkg::col_vec_t col,
    output keypad_pkg::key_map_t key_map,
    output logic                 frame_valid
);

    localparam int DLY_W = $clog2(`SCAN_DELAY + 2);
    localparam int SETTLE_W = $clog2(`SETTLE_TIME + 2);
    localparam int PTR_W = $clog2(`ROW_NUM);

    localparam logic [DLY_W-1:0] DLY_LAST = DLY_W'(`SCAN_DELAY);
    localparam logic [SETTLE_W-1:0] SETTLE_LAST = SETTLE_W'(`SETTLE_TIME);
    localparam logic [PTR_W-1:0] ROW_LAST = PTR_W'(`ROW_NUM - 1);

    keypad_pkg::scan_state_t state;
    keypad_pkg::scan_state_t state_nxt;

    logic [DLY_W-1:0]    dly_cnt;     // row hold counter
    logic [SETTLE_W-1:0] settle_cnt;
    logic [PTR_W-1:0]    row_ptr;     // row under scan

    logic col_hit;
    logic row_done;
    logic last_row;
    logic settle_done;

    assign col_hit = ~&col;  // some column pulled low
    assign row_done = (state == keypad_pkg::SCAN_ROWS) && (dly_cnt == DLY_LAST);
    assign last_row = row_done && (row_ptr == ROW_LAST);
    assign settle_done = (state == keypad_pkg::SCAN_SETTLE) && (settle_cnt == SETTLE_LAST);

    // one low row while scanning and all rows low otherwise
    assign row = (state == keypad_pkg::SCAN_ROWS) ?
                 ~(keypad_pkg::row_vec_t'(1) << row_ptr) : '0;

    always_comb begin
        state_nxt = state;
        case (state)
            keypad_pkg::SCAN_IDLE: begin
                if (col_hit) state_nxt = keypad_pkg::SCAN_ROWS;
            end
            keypad_pkg::SCAN_ROWS: begin
                if (last_row) state_nxt = keypad_pkg::SCAN_SETTLE;
            end
            keypad_pkg::SCAN_SETTLE: begin
                if (settle_done) state_nxt = keypad_pkg::SCAN_IDLE;
            end
            default: state_nxt = keypad_pkg::SCAN_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= keypad_pkg::SCAN_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dly_cnt <= '0;
        end else if (state != keypad_pkg::SCAN_ROWS || row_done) begin
            dly_cnt <= '0;
        end else begin
            dly_cnt <= dly_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            row_ptr <= '0;
        end else if (state != keypad_pkg::SCAN_ROWS) begin
            row_ptr <= '0;
        end else if (row_done) begin
            row_ptr <= row_ptr + 1'b1;  // wraps on the last row and is cleared next cycle
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            settle_cnt <= '0;
        end else if (state == keypad_pkg::SCAN_SETTLE && !settle_done) begin
            settle_cnt <= settle_cnt + 1'b1;
        end else begin
            settle_cnt <= '0;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            key_map     <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            if (row_done) begin
                key_map[row_ptr*`COL_NUM +: `COL_NUM] <= ~col;  // low column means pressed
            end
            if (last_row) begin
                frame_valid <= 1'b1;
            end else if (state == keypad_pkg::SCAN_IDLE && !col_hit && key_map != '0) begin
                // everything let go so publish an empty frame
                key_map     <= '0;
                frame_valid <= 1'b1;
            end
        end
    end

    // the single low level moves one row up per window
    a_row_walk: assert property (@(posedge clk) disable iff (!rstn)
        row_done && !last_row |=> row == {$past(row[`ROW_NUM-2:0]), 1'b1});

    a_frame_pulse: assert property (@(posedge clk) disable iff (!rstn)
        frame_valid |=> !frame_valid);

endmodule

// ==== test/keypad_model.sv ====
`timescale 1ns/10ps
`include "keypad_consts.svh"

module keypad_model (
    input  keypad_pkg::row_vec_t row,
    input  keypad_pkg::key_map_t pressed,
    output keypad_pkg::col_vec_t col
);

    // a closed switch ties its column to its row
    always_comb begin
        col = '1;  // pulled up when nothing conducts
        for (int r = 0; r < `ROW_NUM; r++) begin
            for (int c = 0; c < `COL_NUM; c++) begin
                if (!row[r] && pressed[r * `COL_NUM + c]) begin
                    col[c] = 1'b0;  // active row drags it low
                end
            end
        end
    end

endmodule

// ==== test/keypad_subsys_tb.sv ====
`timescale 1ns/10ps
`include "keypad_consts.svh"

module keypad_subsys_tb;

    localparam int FRAME_CYC = `ROW_NUM * (`SCAN_DELAY + 1) + `SETTLE_TIME + 2;
    localparam int KEY_CHANGES = 24;  // presses and releases of all phases, taps included
    localparam int CYCLE_LIMIT = 2 * KEY_CHANGES * 4 * FRAME_CYC;
    localparam int HOLD_FRAMES = 6;
    localparam int TAP_CYC = 6;       // below SETTLE_TIME
    localparam int SPARE_KEY = 0;     // row 0, so a tap is caught by the scan

    logic                    clk = 1'b0;
    logic                    rstn;
    keypad_pkg::row_vec_t    row;
    keypad_pkg::col_vec_t    col;
    logic                    ev_valid;
    keypad_pkg::event_code_t ev_code;
    logic                    credit_return = 1'b0;

    keypad_pkg::key_map_t    pressed;
    keypad_pkg::event_code_t exp_q[$];  // expected codes in rule order
    int                      grp_q[$];  // codes sharing a group may come in any order
    int                      next_grp;
    int                      outstanding;
    int                      ret_wait;
    logic                    hold_credits;
    logic                    touched;
    logic                    code_bad;
    keypad_pkg::event_code_t bad_code;
    logic [31:0]             lcg_state = 32'h7825_3614;
    int                      err_cnt = 0;
    int                      miss_cnt = 0;
    int                      ev_cnt = 0;
    int                      cycle_cnt = 0;

    always #2 clk = ~clk;

    keypad_subsys DUT (
        .clk           (clk),
        .rstn          (rstn),
        .row           (row),
        .col           (col),
        .ev_valid      (ev_valid),
        .ev_code       (ev_code),
        .credit_return (credit_return)
    );

    keypad_model u_model (
        .row     (row),
        .pressed (pressed),
        .col     (col)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic keypad_pkg::event_code_t make_code(int idx, logic rel);
        keypad_pkg::event_code_t code;
        code = keypad_pkg::event_code_t'(idx);
        code[$bits(code)-1] = rel;  // msb marks a release
        return code;
    endfunction

    task automatic expect_keys(keypad_pkg::key_map_t keys, logic rel);
        for (int i = 0; i < `KEY_NUM; i++) begin
            if (keys[i]) begin
                exp_q.push_back(make_code(i, rel));
                grp_q.push_back(next_grp);
            end
        end
        next_grp++;
    endtask

    task automatic tap_key(int idx);
        @(posedge clk);
        pressed[idx] <= 1'b1;
        repeat (TAP_CYC) @(posedge clk);
        pressed[idx] <= 1'b0;
    endtask

    // the idle clear gives a release only one frame, a spare tap adds the second
    task automatic press_release(keypad_pkg::key_map_t keys);
        expect_keys(keys, 1'b0);
        @(posedge clk);
        pressed <= pressed | keys;
        repeat (HOLD_FRAMES * FRAME_CYC) @(posedge clk);
        expect_keys(keys, 1'b1);
        pressed <= pressed & ~keys;
        repeat (3 * FRAME_CYC) @(posedge clk);
        tap_key(SPARE_KEY);
        repeat (3 * FRAME_CYC) @(posedge clk);
    endtask

    task automatic wait_drained(int max_cyc);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cyc) begin
            @(posedge clk);
            n++;
        end
        a_drained: assert (exp_q.size() == 0) else begin
            miss_cnt += exp_q.size();
            $display("%0d expected key events never arrived", exp_q.size());
            exp_q.delete();
            grp_q.delete();
        end
        repeat (2 * FRAME_CYC) @(posedge clk);  // room for a stray extra event
    endtask

    always @(posedge clk) begin : scoreboard
        int hit;
        hit = -1;
        if (rstn && ev_valid) begin
            for (int k = 0; k < exp_q.size(); k++) begin
                if (hit < 0 && grp_q[k] == grp_q[0] && exp_q[k] == ev_code) begin
                    hit = k;
                end
            end
            if (hit >= 0) begin
                exp_q.delete(hit);
                grp_q.delete(hit);
            end
            ev_cnt <= ev_cnt + 1;
        end
        code_bad <= rstn && ev_valid && hit < 0;
        bad_code <= ev_code;
    end

    // consumer, one credit back per received event after a random pause
    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            credit_return <= 1'b0;
            outstanding   <= 0;
            ret_wait      <= 0;
        end else begin
            outstanding   <= outstanding + int'(ev_valid) - int'(credit_return);
            credit_return <= 1'b0;
            if (!hold_credits && outstanding != 0 && !credit_return) begin
                if (ret_wait == 0) begin
                    credit_return <= 1'b1;
                    ret_wait      <= int'(lcg_next() >> 30);  // 0 to 3 cycles
                end else begin
                    ret_wait <= ret_wait - 1;
                end
            end
        end
    end

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            touched <= 1'b0;
        end else if (pressed != '0) begin
            touched <= 1'b1;
        end
    end

    a_idle_quiet: assert property (@(posedge clk) disable iff (!rstn)
        !touched |-> row == '0 && !ev_valid)
        else begin
            err_cnt++;
            $display("Error at %0t: rows or ev_valid moved before any key press", $time);
        end

    a_code_expected: assert property (@(posedge clk) disable iff (!rstn) !code_bad)
        else begin
            err_cnt++;
            $display("Error at %0t: event code %h not expected", $time, $sampled(bad_code));
        end

    a_credit_limit: assert property (@(posedge clk) disable iff (!rstn)
        outstanding <= `CREDIT_INIT)
        else begin
            err_cnt++;
            $display("Error at %0t: %0d events outstanding", $time, $sampled(outstanding));
        end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", cycle_cnt);
            $display("events %0d, errors %0d, missing %0d", ev_cnt, err_cnt, miss_cnt);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        rstn = 1'b0;
        pressed = '0;
        hold_credits = 1'b0;
        next_grp = 0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        repeat (4 * FRAME_CYC) @(posedge clk);  // idle, nothing pressed

        press_release(keypad_pkg::key_map_t'(1) << 6);
        wait_drained(4 * FRAME_CYC);

        // keys 9 and 14 share no row and no column
        press_release((keypad_pkg::key_map_t'(1) << 9) | (keypad_pkg::key_map_t'(1) << 14));
        wait_drained(4 * FRAME_CYC);

        tap_key(3);  // one frame at most
        repeat (4 * FRAME_CYC) @(posedge clk);

        // two events leave, the other four wait in the fifo
        while (outstanding != 0) @(posedge clk);
        hold_credits <= 1'b1;
        press_release(keypad_pkg::key_map_t'(1) << 7);
        press_release(keypad_pkg::key_map_t'(1) << 11);
        press_release(keypad_pkg::key_map_t'(1) << 13);
        hold_credits <= 1'b0;
        wait_drained(8 * FRAME_CYC);

        $display("events %0d, errors %0d, missing %0d", ev_cnt, err_cnt, miss_cnt);
        if (err_cnt == 0 && miss_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
